// ==== rtl/ptw_cfg_pkg.sv ====
package ptw_cfg_pkg;

    // ------------------------------------------------------------
    // Sv39 address geometry
    // ------------------------------------------------------------

    // virtual address width, bits 63:39 must be a sign extension
    localparam int unsigned va_w = 39;
    // physical address and page number widths
    localparam int unsigned pa_w = 56;
    localparam int unsigned ppn_w = 44;
    // one vpn slice indexes 512 PTEs of a table
    localparam int unsigned vpn_w = 9;
    // three levels, level 2 is the root table
    localparam int unsigned levels = 3;
    localparam int unsigned lvl_w = $clog2(levels);
    // full vpn as stored in the TLB
    localparam int unsigned va_vpn_w = levels * vpn_w;
    // 4 KiB pages
    localparam int unsigned pgoff_w = 12;
    // PTEs are 8 bytes
    localparam int unsigned pte_bytes_log = 3;
    localparam int unsigned asid_w = 16;

    // ------------------------------------------------------------
    // PMP
    // ------------------------------------------------------------

    localparam int unsigned pmp_entries = 4;
    // pmpaddr holds address bits pa_w-1:2
    localparam int unsigned pmp_addr_w = pa_w - 2;

    // ------------------------------------------------------------
    // memory bus
    // ------------------------------------------------------------

    // one PTE per Wishbone beat
    localparam int unsigned wb_dat_w = 64;
    localparam int unsigned wb_sel_w = wb_dat_w / 8;

endpackage

// ==== rtl/ptw_types_pkg.sv ====
package ptw_types_pkg;

    // ------------------------------------------------------------
    // page table entry
    // ------------------------------------------------------------

    // Sv39 PTE, msb first
    typedef struct packed {
        logic [9:0] reserved;
        logic [ptw_cfg_pkg::ppn_w-1:0] ppn;
        // free for supervisor software
        logic [1:0] rsw;
        logic d;
        logic a;
        logic g;
        logic u;
        logic x;
        logic w;
        logic r;
        logic v;
    } pte_t;

    // ------------------------------------------------------------
    // miss intake and TLB update
    // ------------------------------------------------------------

    typedef struct packed {
        logic [ptw_cfg_pkg::va_w-1:0] vaddr;
        logic is_instr;
        // only meaningful for data misses
        logic is_store;
        // make executable pages readable
        logic mxr;
        logic [ptw_cfg_pkg::ppn_w-1:0] satp_ppn;
        logic [ptw_cfg_pkg::asid_w-1:0] asid;
    } miss_req_t;

    typedef struct packed {
        logic [ptw_cfg_pkg::va_vpn_w-1:0] vpn;
        logic [ptw_cfg_pkg::asid_w-1:0] asid;
        logic is_1g;
        logic is_2m;
        // leaf PTE, g is the OR over the whole walk
        pte_t content;
    } tlb_update_t;

    typedef enum logic [1:0] {
        fault_none = 2'd0,
        fault_page = 2'd1,
        fault_access = 2'd2
    } walk_fault_e;

    // ------------------------------------------------------------
    // Wishbone classic
    // ------------------------------------------------------------

    typedef struct packed {
        logic cyc;
        logic stb;
        logic we;
        logic [ptw_cfg_pkg::pa_w-1:0] adr;
        logic [ptw_cfg_pkg::wb_sel_w-1:0] sel;
    } wb_m2s_t;

    typedef struct packed {
        logic ack;
        logic [ptw_cfg_pkg::wb_dat_w-1:0] dat;
    } wb_s2m_t;

    // ------------------------------------------------------------
    // PMP
    // ------------------------------------------------------------

    // RISC-V A field encodings, TOR and NA4 are not handled
    typedef enum logic [1:0] {
        pmp_off = 2'b00,
        pmp_napot = 2'b11
    } pmp_mode_e;

    // one pmpcfg byte, lock and reserved bits folded into rsvd
    typedef struct packed {
        logic [2:0] rsvd;
        pmp_mode_e mode;
        logic x;
        logic w;
        logic r;
    } pmpcfg_t;

    // per entry result towards the resolver
    typedef struct packed {
        logic match;
        logic r;
    } pmp_hit_t;

endpackage

// ==== rtl/pmp_entry.sv ====
`timescale 1ns/1ps

module pmp_entry (
    input  logic [ptw_cfg_pkg::pa_w-1:0] addr_i,
    input  ptw_types_pkg::pmpcfg_t cfg_i,
    input  logic [ptw_cfg_pkg::pmp_addr_w-1:0] pmpaddr_i,
    output ptw_types_pkg::pmp_hit_t match_o
);

    // ------------------------------------------------------------
    // NAPOT decode
    // ------------------------------------------------------------

    // k trailing ones in pmpaddr give a 2^(k+3) byte region
    // adding one clears those ones and sets the next zero,
    // so the xor marks the k+1 low bits that are don't-care
    logic [ptw_cfg_pkg::pmp_addr_w-1:0] napot_mask;
    logic [ptw_cfg_pkg::pmp_addr_w-1:0] word_addr;
    logic in_range;

    assign napot_mask = ~(pmpaddr_i ^ (pmpaddr_i + 1'b1));

    // pmpaddr counts 4-byte words
    assign word_addr = addr_i[ptw_cfg_pkg::pa_w-1:2];

    // an all-ones pmpaddr masks everything and covers the whole space
    assign in_range = (word_addr & napot_mask) == (pmpaddr_i & napot_mask);

    // ------------------------------------------------------------
    // result
    // ------------------------------------------------------------

    always_comb begin
        // OFF never matches, the walker only ever loads so r is all we report
        match_o.match = (cfg_i.mode == ptw_types_pkg::pmp_napot) && in_range;
        match_o.r = cfg_i.r;
    end

endmodule

// ==== rtl/pmp_resolve.sv ====
`timescale 1ns/1ps

module pmp_resolve (
    input  ptw_types_pkg::pmp_hit_t [ptw_cfg_pkg::pmp_entries-1:0] hits_i,
    output logic allow_o
);

    logic [ptw_cfg_pkg::pmp_entries-1:0] match_vec;

    for (genvar i = 0; i < ptw_cfg_pkg::pmp_entries; i++) begin : gen_match
        assign match_vec[i] = hits_i[i].match;
    end

    // ------------------------------------------------------------
    // priority
    // ------------------------------------------------------------

    always_comb begin
        // no match denies in S-mode
        allow_o = 1'b0;
        // walk from the top so the lowest matching entry is written last
        for (int i = ptw_cfg_pkg::pmp_entries - 1; i >= 0; i--) begin
            if (match_vec[i]) begin
                allow_o = hits_i[i].r;
            end
        end
    end

endmodule

// ==== rtl/ptw_walker.sv ====
`timescale 1ns/1ps

module ptw_walker (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic flush_i,
    input  logic miss_valid_i,
    input  ptw_types_pkg::miss_req_t miss_i,
    output logic busy_o,
    output ptw_types_pkg::wb_m2s_t wb_o,
    input  ptw_types_pkg::wb_s2m_t wb_i,
    output logic [ptw_cfg_pkg::pa_w-1:0] pte_addr_o,
    input  logic pmp_allow_i,
    output logic update_valid_o,
    output ptw_types_pkg::tlb_update_t update_o,
    output ptw_types_pkg::walk_fault_e fault_o
);

    typedef enum logic [2:0] {
        st_idle,
        st_pmp_check,
        st_bus_wait,
        st_pte_lookup,
        st_result,
        st_drain,
        st_latency
    } state_e;

    state_e state_q, state_d;
    ptw_types_pkg::miss_req_t req_q;
    // level 2 is the root table
    logic [ptw_cfg_pkg::lvl_w-1:0] lvl_q, lvl_d;
    // base page of the table being walked
    logic [ptw_cfg_pkg::ppn_w-1:0] ptr_q, ptr_d;
    ptw_types_pkg::pte_t pte_q;
    logic glob_q, glob_d;
    ptw_types_pkg::walk_fault_e res_q, res_d;

    logic [ptw_cfg_pkg::vpn_w-1:0] vpn_slice;
    logic [ptw_cfg_pkg::ppn_w-1:0] low_mask;
    logic is_leaf, bad_pte, perm_fault, misaligned;

    // ------------------------------------------------------------
    // PTE address and checks
    // ------------------------------------------------------------

    // vpn[lvl] picks the entry inside the current table
    assign vpn_slice = req_q.vaddr[ptw_cfg_pkg::pgoff_w + ptw_cfg_pkg::vpn_w * lvl_q
                                   +: ptw_cfg_pkg::vpn_w];
    assign pte_addr_o = {ptr_q, vpn_slice, ptw_cfg_pkg::pte_bytes_log'(0)};

    // ppn slices below the leaf level must be zero on a superpage
    assign low_mask = (ptw_cfg_pkg::ppn_w'(1) << (ptw_cfg_pkg::vpn_w * lvl_q))
                      - ptw_cfg_pkg::ppn_w'(1);
    assign misaligned = |(pte_q.ppn & low_mask);

    assign is_leaf = pte_q.r || pte_q.x;
    // invalid, or the reserved w-without-r encoding
    assign bad_pte = !pte_q.v || (pte_q.w && !pte_q.r);

    always_comb begin
        if (req_q.is_instr) begin
            perm_fault = !pte_q.x || !pte_q.a;
        end else begin
            // execute-only pages are readable only under mxr
            perm_fault = !pte_q.a || !(pte_q.r || (pte_q.x && req_q.mxr));
            // A/D are managed by software, so a clean page faults on a store
            if (req_q.is_store && (!pte_q.w || !pte_q.d)) begin
                perm_fault = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // walk FSM
    // ------------------------------------------------------------

    always_comb begin
        state_d = state_q;
        lvl_d = lvl_q;
        ptr_d = ptr_q;
        glob_d = glob_q;
        res_d = res_q;
        case (state_q)
            st_idle: begin
                if (miss_valid_i) begin
                    state_d = st_pmp_check;
                    lvl_d = ptw_cfg_pkg::lvl_w'(ptw_cfg_pkg::levels - 1);
                    ptr_d = miss_i.satp_ppn;
                    glob_d = 1'b0;
                    res_d = ptw_types_pkg::fault_none;
                end
            end
            // PMP runs combinationally on pte_addr_o
            st_pmp_check: begin
                if (pmp_allow_i) begin
                    state_d = st_bus_wait;
                end else begin
                    res_d = ptw_types_pkg::fault_access;
                    state_d = st_result;
                end
            end
            st_bus_wait: begin
                if (wb_i.ack) begin
                    state_d = st_pte_lookup;
                end
            end
            st_pte_lookup: begin
                glob_d = glob_q | pte_q.g;
                state_d = st_result;
                if (bad_pte) begin
                    res_d = ptw_types_pkg::fault_page;
                end else if (!is_leaf) begin
                    // pointer, descend unless we are already at the last level
                    if (lvl_q == '0) begin
                        res_d = ptw_types_pkg::fault_page;
                    end else begin
                        lvl_d = lvl_q - 1'b1;
                        ptr_d = pte_q.ppn;
                        state_d = st_pmp_check;
                    end
                end else if (perm_fault || misaligned) begin
                    res_d = ptw_types_pkg::fault_page;
                end
            end
            st_result: state_d = st_latency;
            // flushed with a bus cycle open
            st_drain: begin
                if (wb_i.ack) begin
                    state_d = st_latency;
                end
            end
            default: state_d = st_idle;
        endcase

        // flush drops the walk, an open bus cycle still has to see its ack
        if (flush_i && state_q != st_idle) begin
            if ((state_q == st_bus_wait || state_q == st_drain) && !wb_i.ack) begin
                state_d = st_drain;
            end else begin
                state_d = st_latency;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= st_idle;
            lvl_q <= '0;
            glob_q <= 1'b0;
            res_q <= ptw_types_pkg::fault_none;
        end else begin
            state_q <= state_d;
            lvl_q <= lvl_d;
            glob_q <= glob_d;
            res_q <= res_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == st_idle && miss_valid_i) begin
            req_q <= miss_i;
        end
        ptr_q <= ptr_d;
        // PTE is evaluated in the cycle after its ack
        if (state_q == st_bus_wait && wb_i.ack) begin
            pte_q <= wb_i.dat;
        end
    end

    // ------------------------------------------------------------
    // outputs
    // ------------------------------------------------------------

    always_comb begin
        busy_o = (state_q != st_idle);
        // read only, one full 64-bit word per cycle
        wb_o.cyc = (state_q == st_bus_wait) || (state_q == st_drain);
        wb_o.stb = wb_o.cyc;
        wb_o.we = 1'b0;
        wb_o.sel = '1;
        wb_o.adr = pte_addr_o;

        update_valid_o = (state_q == st_result) && (res_q == ptw_types_pkg::fault_none);
        fault_o = (state_q == st_result) ? res_q : ptw_types_pkg::fault_none;

        update_o.vpn = req_q.vaddr[ptw_cfg_pkg::va_w-1:ptw_cfg_pkg::pgoff_w];
        update_o.asid = req_q.asid;
        // leaf level gives the page size
        update_o.is_1g = (lvl_q == ptw_cfg_pkg::lvl_w'(2));
        update_o.is_2m = (lvl_q == ptw_cfg_pkg::lvl_w'(1));
        update_o.content = pte_q;
        update_o.content.g = pte_q.g | glob_q;
    end

    // ------------------------------------------------------------
    // assertions
    // ------------------------------------------------------------

    // a classic cycle closes right after its ack
    cyc_drops_after_ack_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wb_o.cyc && wb_i.ack |=> !wb_o.cyc);

    // address held across wait states
    adr_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wb_o.stb && !wb_i.ack |=> $stable(wb_o.adr));

    // results are single-cycle pulses
    result_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (update_valid_o || fault_o != ptw_types_pkg::fault_none)
        |=> (!update_valid_o && fault_o == ptw_types_pkg::fault_none));

endmodule

// ==== rtl/ptw_top.sv ====
`timescale 1ns/1ps

module ptw_top (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic flush_i,
    // miss intake
    input  logic miss_valid_i,
    input  ptw_types_pkg::miss_req_t miss_i,
    output logic busy_o,
    // page table memory
    output ptw_types_pkg::wb_m2s_t wb_o,
    input  ptw_types_pkg::wb_s2m_t wb_i,
    // PMP configuration
    input  ptw_types_pkg::pmpcfg_t [ptw_cfg_pkg::pmp_entries-1:0] pmpcfg_i,
    input  logic [ptw_cfg_pkg::pmp_entries-1:0][ptw_cfg_pkg::pmp_addr_w-1:0] pmpaddr_i,
    // walk results
    output logic update_valid_o,
    output ptw_types_pkg::tlb_update_t update_o,
    output ptw_types_pkg::walk_fault_e fault_o
);

    // address of the PTE about to be read
    logic [ptw_cfg_pkg::pa_w-1:0] pte_addr;
    logic pmp_allow;
    ptw_types_pkg::pmp_hit_t [ptw_cfg_pkg::pmp_entries-1:0] pmp_hits;

    ptw_walker ptw_walker_i (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .flush_i        (flush_i),
        .miss_valid_i   (miss_valid_i),
        .miss_i         (miss_i),
        .busy_o         (busy_o),
        .wb_o           (wb_o),
        .wb_i           (wb_i),
        .pte_addr_o     (pte_addr),
        .pmp_allow_i    (pmp_allow),
        .update_valid_o (update_valid_o),
        .update_o       (update_o),
        .fault_o        (fault_o)
    );

    // every entry sees the same PTE address
    for (genvar i = 0; i < ptw_cfg_pkg::pmp_entries; i++) begin : gen_pmp
        pmp_entry pmp_entry_i (
            .addr_i     (pte_addr),
            .cfg_i      (pmpcfg_i[i]),
            .pmpaddr_i  (pmpaddr_i[i]),
            .match_o    (pmp_hits[i])
        );
    end

    // lowest matching entry wins
    pmp_resolve pmp_resolve_i (
        .hits_i  (pmp_hits),
        .allow_o (pmp_allow)
    );

endmodule

// ==== testbench/tb_ptw.sv ====
`timescale 1ns/1ps

module tb_ptw;

    localparam int unsigned num_walks = 600;
    localparam int unsigned timeout_ns = num_walks * 40 * 4;
    localparam logic [31:0] seed = 32'h91c8_072b;
    // 16 MiB table region at 0x8000_0000, NAPOT encoded
    localparam logic [ptw_cfg_pkg::pmp_addr_w-1:0] region_napot = 54'h2000_0000 | 54'h1f_ffff;

    logic clk_i = 1'b0;
    logic rst_ni;
    logic flush_i;
    logic miss_valid_i;
    ptw_types_pkg::miss_req_t miss_i;
    logic busy_o;
    ptw_types_pkg::wb_m2s_t wb_o;
    ptw_types_pkg::wb_s2m_t wb_i = '0;
    ptw_types_pkg::pmpcfg_t [ptw_cfg_pkg::pmp_entries-1:0] pmpcfg_i;
    logic [ptw_cfg_pkg::pmp_entries-1:0][ptw_cfg_pkg::pmp_addr_w-1:0] pmpaddr_i;
    logic update_valid_o;
    ptw_types_pkg::tlb_update_t update_o;
    ptw_types_pkg::walk_fault_e fault_o;

    // page table memory, unwritten words read as zero
    logic [63:0] mem [logic [ptw_cfg_pkg::pa_w-1:0]];
    logic [ptw_cfg_pkg::pa_w-1:0] bus_log [$];
    logic [31:0] lcg_state;
    logic [31:0] wait_state;
    logic in_cycle = 1'b0;
    int waits = 0;
    int errors = 0;
    int n_upd = 0;
    int n_page = 0;
    int n_access = 0;
    int n_flush = 0;

    ptw_top ptw_top_i (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .flush_i        (flush_i),
        .miss_valid_i   (miss_valid_i),
        .miss_i         (miss_i),
        .busy_o         (busy_o),
        .wb_o           (wb_o),
        .wb_i           (wb_i),
        .pmpcfg_i       (pmpcfg_i),
        .pmpaddr_i      (pmpaddr_i),
        .update_valid_o (update_valid_o),
        .update_o       (update_o),
        .fault_o        (fault_o)
    );

    always #2 clk_i = ~clk_i;

    // ------------------------------------------------------------
    // random numbers and helpers
    // ------------------------------------------------------------

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // halves swapped so the weak low bits end up on top
    function automatic logic [31:0] next_random();
        lcg_state = lcg_step(lcg_state);
        return {lcg_state[15:0], lcg_state[31:16]};
    endfunction

    function automatic logic [63:0] mem_read(input logic [ptw_cfg_pkg::pa_w-1:0] a);
        return mem.exists(a) ? mem[a] : 64'h0;
    endfunction

    function automatic logic [ptw_cfg_pkg::pa_w-1:0] pte_addr_of(
            input logic [ptw_cfg_pkg::ppn_w-1:0] table_ppn,
            input logic [ptw_cfg_pkg::va_w-1:0] va,
            input int lvl);
        return {table_ppn, va[12 + 9 * lvl +: 9], 3'b000};
    endfunction

    task automatic report_error(input string msg);
        errors++;
        $display("ERR %0t ns: %s", $time, msg);
    endtask

    task automatic check_update(input ptw_types_pkg::tlb_update_t got,
                                input ptw_types_pkg::tlb_update_t exp);
        if (got !== exp) begin
            report_error($sformatf("update got %h expected %h", got, exp));
        end
    endtask

    task automatic check_fault(input ptw_types_pkg::walk_fault_e got,
                               input ptw_types_pkg::walk_fault_e exp,
                               input string what);
        if (got !== exp) begin
            report_error($sformatf("%s fault got %s expected %s", what, got.name(), exp.name()));
        end
    endtask

    // PTE reads are full-word reads with we low
    task automatic check_bus(input ptw_types_pkg::wb_m2s_t got);
        if (got.we !== 1'b0 || got.sel !== '1) begin
            report_error($sformatf("bus read with we %b sel %h", got.we, got.sel));
        end
    endtask

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------

    // size of a NAPOT region from the count of trailing ones
    function automatic logic pmp_allows(input logic [ptw_cfg_pkg::pa_w-1:0] addr);
        int k;
        logic [ptw_cfg_pkg::pa_w-1:0] base;
        for (int i = 0; i < ptw_cfg_pkg::pmp_entries; i++) begin
            if (pmpcfg_i[i].mode == ptw_types_pkg::pmp_napot) begin
                k = 0;
                while (k < ptw_cfg_pkg::pmp_addr_w && pmpaddr_i[i][k]) begin
                    k++;
                end
                base = {pmpaddr_i[i], 2'b00};
                // first match decides
                if ((addr >> (k + 3)) == (base >> (k + 3))) begin
                    return pmpcfg_i[i].r;
                end
            end
        end
        // S-mode with no match
        return 1'b0;
    endfunction

    function automatic void model_walk(input ptw_types_pkg::miss_req_t req,
                                       output ptw_types_pkg::tlb_update_t upd,
                                       output ptw_types_pkg::walk_fault_e flt,
                                       output logic [ptw_cfg_pkg::pa_w-1:0] deny);
        logic [ptw_cfg_pkg::ppn_w-1:0] ptr;
        logic [ptw_cfg_pkg::pa_w-1:0] addr;
        ptw_types_pkg::pte_t pte;
        logic glob;
        logic ok;
        logic mis;
        ptr = req.satp_ppn;
        glob = 1'b0;
        upd = '0;
        deny = '0;
        flt = ptw_types_pkg::fault_page;
        for (int lvl = 2; lvl >= 0; lvl--) begin
            addr = pte_addr_of(ptr, req.vaddr, lvl);
            if (!pmp_allows(addr)) begin
                flt = ptw_types_pkg::fault_access;
                deny = addr;
                return;
            end
            pte = mem_read(addr);
            glob = glob | pte.g;
            if (!pte.v || (pte.w && !pte.r)) begin
                return;
            end
            if (!pte.r && !pte.x) begin
                // pointer, none allowed in the last table
                if (lvl == 0) begin
                    return;
                end
                ptr = pte.ppn;
            end else begin
                if (req.is_instr) begin
                    ok = pte.x && pte.a;
                end else begin
                    ok = pte.a && (pte.r || (req.mxr && pte.x));
                    if (req.is_store) begin
                        ok = ok && pte.w && pte.d;
                    end
                end
                mis = 1'b0;
                for (int s = 0; s < lvl; s++) begin
                    mis = mis | (pte.ppn[9 * s +: 9] != 9'd0);
                end
                if (!ok || mis) begin
                    return;
                end
                flt = ptw_types_pkg::fault_none;
                upd.vpn = req.vaddr[ptw_cfg_pkg::va_w-1:ptw_cfg_pkg::pgoff_w];
                upd.asid = req.asid;
                upd.is_1g = (lvl == 2);
                upd.is_2m = (lvl == 1);
                upd.content = pte;
                upd.content.g = glob;
                return;
            end
        end
    endfunction

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------

    task automatic build_walk(output ptw_types_pkg::miss_req_t req,
                              output logic [ptw_cfg_pkg::ppn_w-1:0] l1_ppn);
        logic [ptw_cfg_pkg::ppn_w-1:0] tbl [3];
        ptw_types_pkg::pte_t p;
        logic [31:0] t;
        logic [63:0] r64;
        int leaf_lvl;
        int kind;
        mem.delete();
        // three disjoint table areas inside the region
        t = next_random();
        tbl[2] = 44'h8_0000 | {34'd0, t[9:0]};
        tbl[1] = 44'h8_0400 | {34'd0, t[19:10]};
        tbl[0] = 44'h8_0800 | {34'd0, t[29:20]};
        l1_ppn = tbl[1];
        r64 = {next_random(), next_random()};
        t = next_random();
        req = '0;
        req.vaddr = r64[38:0];
        req.asid = r64[54:39];
        req.is_instr = (t[1:0] == 2'd0);
        req.is_store = !req.is_instr && t[2];
        req.mxr = t[3];
        req.satp_ppn = tbl[2];
        leaf_lvl = int'(t[5:4]) % 3;
        kind = int'(t[11:8]);
        // pointers down to the leaf table, g on about a quarter
        for (int lvl = 2; lvl > leaf_lvl; lvl--) begin
            p = '0;
            p.v = 1'b1;
            p.ppn = tbl[lvl-1];
            p.g = t[16+lvl] & t[19+lvl];
            mem[pte_addr_of(tbl[lvl], req.vaddr, lvl)] = p;
        end
        // a leaf that suits the request
        r64 = {next_random(), next_random()};
        p = '0;
        p.v = 1'b1;
        p.a = 1'b1;
        p.ppn = r64[43:0];
        for (int s = 0; s < leaf_lvl; s++) begin
            p.ppn[9 * s +: 9] = '0;
        end
        p.u = r64[44];
        p.g = r64[45] & r64[46];
        p.d = r64[47];
        p.rsw = r64[49:48];
        if (req.is_instr) begin
            p.x = 1'b1;
            p.r = r64[50];
            p.w = p.r & r64[51];
        end else begin
            p.r = 1'b1;
            p.x = r64[50];
            p.w = r64[51] | req.is_store;
            p.d = p.d | req.is_store;
        end
        // then break it in one way, or leave it
        case (kind)
            0: p.v = 1'b0;
            1: {p.r, p.w} = 2'b01;
            2: {p.r, p.w, p.x} = 3'b000;
            3: p.a = 1'b0;
            4: p.x = 1'b0;
            5: p.w = 1'b0;
            6: p.d = 1'b0;
            7: {p.r, p.w, p.x} = 3'b001;
            8: p.ppn[0] = (leaf_lvl > 0);
            default: ;
        endcase
        mem[pte_addr_of(tbl[leaf_lvl], req.vaddr, leaf_lvl)] = p;
        // invalid root pointer
        if (kind == 9 && leaf_lvl < 2) begin
            p = '0;
            p.ppn = tbl[1];
            mem[pte_addr_of(tbl[2], req.vaddr, 2)] = p;
        end
    endtask

    // entry 3 always denies everything, so lower entries take priority
    task automatic setup_pmp(input logic [ptw_cfg_pkg::ppn_w-1:0] l1_ppn);
        int mode;
        mode = int'(next_random() % 32'd12);
        pmpcfg_i = '0;
        pmpaddr_i = '0;
        pmpcfg_i[3].mode = ptw_types_pkg::pmp_napot;
        pmpaddr_i[3] = '1;
        case (mode)
            0: ;
            1: begin
                pmpcfg_i[0].mode = ptw_types_pkg::pmp_napot;
                pmpaddr_i[0] = region_napot;
            end
            2: begin
                // 4 KiB hole over the level-1 table
                pmpcfg_i[0].mode = ptw_types_pkg::pmp_napot;
                pmpaddr_i[0] = {l1_ppn, 10'h1ff};
                pmpcfg_i[1].mode = ptw_types_pkg::pmp_napot;
                pmpcfg_i[1].r = 1'b1;
                pmpaddr_i[1] = region_napot;
            end
            default: begin
                pmpcfg_i[mode % 3].mode = ptw_types_pkg::pmp_napot;
                pmpcfg_i[mode % 3].r = 1'b1;
                pmpcfg_i[mode % 3].x = mode[0];
                pmpaddr_i[mode % 3] = region_napot;
            end
        endcase
    endtask

    task automatic run_walk();
        ptw_types_pkg::miss_req_t req;
        ptw_types_pkg::tlb_update_t exp_upd;
        ptw_types_pkg::tlb_update_t got_upd;
        ptw_types_pkg::walk_fault_e exp_flt;
        ptw_types_pkg::walk_fault_e got_flt;
        logic [ptw_cfg_pkg::pa_w-1:0] deny;
        logic [ptw_cfg_pkg::ppn_w-1:0] l1_ppn;
        logic [31:0] t;
        logic prev_cyc;
        logic flushed;
        int pulses;
        int bus_idx;
        int flush_at;
        build_walk(req, l1_ppn);
        setup_pmp(l1_ppn);
        model_walk(req, exp_upd, exp_flt, deny);
        // every eighth walk is flushed during one of its bus cycles
        t = next_random();
        flush_at = (t[2:0] == 3'd0) ? 1 + int'(t[4:3]) % 3 : 0;
        bus_log.delete();
        miss_valid_i = 1'b1;
        miss_i = req;
        @(negedge clk_i);
        miss_valid_i = 1'b0;
        pulses = 0;
        got_upd = '0;
        got_flt = ptw_types_pkg::fault_none;
        prev_cyc = 1'b0;
        bus_idx = 0;
        flushed = 1'b0;
        while (busy_o) begin
            if (update_valid_o) begin
                pulses++;
                got_upd = update_o;
            end
            if (fault_o != ptw_types_pkg::fault_none) begin
                pulses++;
                got_flt = fault_o;
            end
            if (wb_o.cyc && !prev_cyc) begin
                bus_idx++;
            end
            prev_cyc = wb_o.cyc;
            flush_i = 1'b0;
            if (flush_at != 0 && !flushed && wb_o.cyc && bus_idx == flush_at) begin
                flush_i = 1'b1;
                flushed = 1'b1;
            end
            @(negedge clk_i);
        end
        flush_i = 1'b0;
        if (flushed) begin
            n_flush++;
            check_fault(got_flt, ptw_types_pkg::fault_none, "flushed walk");
            if (pulses != 0) begin
                report_error($sformatf("flushed walk gave %0d result pulses", pulses));
            end
        end else begin
            if (pulses != 1) begin
                report_error($sformatf("expected one result pulse, saw %0d", pulses));
            end
            check_fault(got_flt, exp_flt, "walk");
            case (exp_flt)
                ptw_types_pkg::fault_none: begin
                    n_upd++;
                    check_update(got_upd, exp_upd);
                end
                ptw_types_pkg::fault_page: n_page++;
                default: begin
                    n_access++;
                    foreach (bus_log[i]) begin
                        if (bus_log[i] == deny) begin
                            report_error($sformatf("bus read of denied address %h", deny));
                        end
                    end
                end
            endcase
        end
    endtask

    // ------------------------------------------------------------
    // Wishbone slave, 0 to 3 wait states
    // ------------------------------------------------------------

    always @(negedge clk_i) begin
        if (!rst_ni) begin
            wb_i = '0;
            in_cycle = 1'b0;
        end else if (wb_i.ack) begin
            // single-cycle ack, strobes drop after it
            wb_i.ack = 1'b0;
            in_cycle = 1'b0;
        end else if (wb_o.cyc && wb_o.stb) begin
            check_bus(wb_o);
            if (!in_cycle) begin
                in_cycle = 1'b1;
                wait_state = lcg_step(wait_state);
                waits = int'(wait_state[17:16]);
                bus_log.push_back(wb_o.adr);
            end
            if (waits == 0) begin
                wb_i.ack = 1'b1;
                wb_i.dat = mem_read(wb_o.adr);
            end else begin
                waits--;
            end
        end
    end

    // ------------------------------------------------------------
    // main sequence and watchdog
    // ------------------------------------------------------------

    initial begin
        rst_ni = 1'b0;
        flush_i = 1'b0;
        miss_valid_i = 1'b0;
        miss_i = '0;
        pmpcfg_i = '0;
        pmpaddr_i = '0;
        lcg_state = seed;
        wait_state = lcg_step(~seed);
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        @(negedge clk_i);
        // idle outputs out of reset
        if (busy_o !== 1'b0 || wb_o.cyc !== 1'b0 || wb_o.stb !== 1'b0
                || update_valid_o !== 1'b0) begin
            report_error("outputs not idle after reset");
        end
        check_fault(fault_o, ptw_types_pkg::fault_none, "reset");
        for (int n = 0; n < num_walks; n++) begin
            run_walk();
        end
        $display("walks %0d updates %0d page %0d access %0d flushes %0d errors %0d",
                 num_walks, n_upd, n_page, n_access, n_flush, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("timeout: the walker did not finish all walks within %0d ns", timeout_ns);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== flist.f ====
rtl/ptw_cfg_pkg.sv
rtl/ptw_types_pkg.sv
rtl/pmp_entry.sv
rtl/pmp_resolve.sv
rtl/ptw_walker.sv
rtl/ptw_top.sv
testbench/tb_ptw.sv

// ==== Makefile ====
# Verilator build and run of the Sv39 page-table walker testbench

VERILATOR ?= verilator
TOP       ?= tb_ptw
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Result: PASSED" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
